/* files.f */
mix_pkg.sv
cmos_capture.sv
async_fifo.sv
line_mixer.sv
mix_image.sv
tb_clk_gen.sv
tb_cmos_model.sv
tb_mix_image.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_mix_image -f files.f
./obj_dir/Vtb_mix_image

/* tb_mix_image.sv */
module tb_mix_image import mix_pkg::*; ();

  localparam int n_frames = 8;
  localparam int frame_px = img_w * half_h;  // output pixels per frame
  localparam int wait_max = 5000;            // clk cycles

  logic                    clk;
  logic                    cam1_pclk;
  logic                    cam2_pclk;
  logic                    rst;
  logic [shift_w_bits-1:0] shift_w;
  logic                    cam1_vsync;
  logic                    cam1_href;
  logic                    cam2_vsync;
  logic                    cam2_href;
  logic [pix_w-1:0]        cam1_data;
  logic [pix_w-1:0]        cam2_data;
  logic [pix_w-1:0]        pix_data;
  logic                    frame_start;
  logic                    pix_valid;
  logic [pix_w-1:0]        exp_q[$];   // expected output in order
  logic [pix_w-1:0]        exp_word;
  logic [31:0]             rng_state;
  int                      out_count = 0;
  int                      fs_count = 0;  // frame_start pulses seen
  int                      shift;
  int                      timer;

  tb_clk_gen #(.half_period(2)) sys_clk_gen (.clk(clk));
  tb_clk_gen #(.half_period(3)) pclk1_gen (.clk(cam1_pclk));
  tb_clk_gen #(.half_period(5)) pclk2_gen (.clk(cam2_pclk));

  tb_cmos_model #(.cam_id(1), .seed(12)) cam1 (
    .pclk(cam1_pclk), .vsync(cam1_vsync), .href(cam1_href), .data(cam1_data)
  );
  tb_cmos_model #(.cam_id(2), .seed(12)) cam2 (
    .pclk(cam2_pclk), .vsync(cam2_vsync), .href(cam2_href), .data(cam2_data)
  );

  mix_image UUT (
    .clk(clk), .rst(rst), .shift_w(shift_w),
    .cam1_pclk(cam1_pclk), .cam1_vsync(cam1_vsync), .cam1_href(cam1_href),
    .cam1_data(cam1_data), .cam2_pclk(cam2_pclk), .cam2_vsync(cam2_vsync),
    .cam2_href(cam2_href), .cam2_data(cam2_data),
    .frame_start(frame_start), .pix_valid(pix_valid), .pix_data(pix_data)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [pix_w-1:0] pixel_word(input int cam, input int frame_no,
                                                  input int row, input int col);
    return {cam == 2, 7'(frame_no), 4'(row), 4'(col)};
  endfunction

  task automatic stop_on_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    $display("FAILED %s: got 0x%h, expected 0x%h", name, got, want);
    $display("Test FAILED");
    $fatal(1, "value check failed");
  endtask

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Test FAILED");
    $fatal(1, "run aborted");
  endtask

  ////////////////////
  // expected lines as left half then shifted right half then zero pad
  ////////////////////
  task automatic push_expected(input int frame_no, input int sh);
    for (int r = 0; r < half_h; r++) begin
      for (int k = 0; k < img_w; k++) begin
        if (k < half_w) exp_q.push_back(pixel_word(1, frame_no, 2 * r, 2 * k));
        else if (k < img_w - sh)
          exp_q.push_back(pixel_word(2, frame_no, 2 * r, 2 * (k - half_w + sh)));
        else exp_q.push_back('0);  // pad
      end
    end
  endtask

  // monitor reads what the previous edge registered
  always @(posedge clk) begin
    if (pix_valid) begin
      assert (exp_q.size() != 0) else stop_on_error("valid pixel seen with none expected");
      exp_word = exp_q.pop_front();
      assert (pix_data == exp_word) else stop_on_value("pix_data", 32'(pix_data), 32'(exp_word));
      if (out_count % frame_px == 0) begin  // first pixel of a frame
        assert (fs_count == out_count / frame_px + 1)
          else stop_on_value("frame_start count", 32'(fs_count), 32'(out_count / frame_px + 1));
      end
      out_count++;
    end
    if (frame_start) fs_count++;
  end

  ////////////////////
  // stimulus
  ////////////////////
  initial begin
    rst       = 1'b1;
    shift_w   = '0;
    rng_state = 32'd12;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    fork  // junk before first vsync
      cam1.send_stray();
      cam2.send_stray();
    join
    for (int f = 1; f <= n_frames; f++) begin
      rng_state = xorshift32(rng_state);
      if (f <= 2) shift = 0;                  // full right half
      else if (f <= 4) shift = half_w - 1;    // single camera 2 pixel
      else shift = int'(rng_state % 32'(half_w));
      @(posedge clk);
      shift_w <= shift_w_bits'(shift);        // mixer sits idle here
      push_expected(f, shift);
      fork
        cam1.send_frame(f);
        cam2.send_frame(f);
      join
      timer = 0;
      while (out_count < f * frame_px) begin
        @(negedge clk);
        timer++;
        if (timer > wait_max) stop_on_error($sformatf("timeout on output of frame %0d", f));
      end
    end
    repeat (50) @(negedge clk);  // room for any extra pixel
    assert (fs_count == n_frames) begin
      $display("Test OK");
      $finish;
    end else begin
      stop_on_value("frame_start count", 32'(fs_count), 32'(n_frames));
    end
  end

endmodule

/* tb_cmos_model.sv */
module tb_cmos_model import mix_pkg::*; #(
  parameter int cam_id = 1,   // goes into the top bit of every word
  parameter int seed   = 12
) (
  input  logic             pclk,
  output logic             vsync,
  output logic             href,
  output logic [pix_w-1:0] data
);

  logic [31:0] rng;  // line gap state

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  initial begin
    vsync = 1'b0;
    href  = 1'b0;
    data  = '0;
    rng   = 32'(seed);
  end

  // one full line, then href low for 1..8 clocks
  task automatic send_line(input int frame_no, input int row);
    int gap;
    for (int c = 0; c < img_w; c++) begin
      @(posedge pclk);
      href <= 1'b1;
      data <= {cam_id == 2, 7'(frame_no), 4'(row), 4'(c)}; // cam, frame, row, col
    end
    @(posedge pclk);
    href <= 1'b0;
    rng = xorshift32(rng);
    gap = 1 + int'(rng[2:0]);
    repeat (gap) @(posedge pclk);
  endtask

  task automatic send_frame(input int frame_no);
    @(posedge pclk);
    vsync <= 1'b1;
    repeat (3) @(posedge pclk);  // wide enough for clk to see it
    vsync <= 1'b0;
    repeat (6) @(posedge pclk);  // counters clear meanwhile
    for (int r = 0; r < img_h; r++) send_line(frame_no, r);
  endtask

  // lines before any vsync, frame code 127 marks them
  task automatic send_stray();
    for (int r = 0; r < 2; r++) send_line(127, r);
  endtask

endmodule

/* tb_clk_gen.sv */
module tb_clk_gen #(
  parameter int half_period = 2  // time units, period is twice this
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;  // free running
  end

endmodule

/* mix_image.sv */
module mix_image import mix_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [shift_w_bits-1:0] shift_w,
  input  logic                    cam1_pclk,
  input  logic                    cam1_vsync,
  input  logic                    cam1_href,
  input  logic [pix_w-1:0]        cam1_data,
  input  logic                    cam2_pclk,
  input  logic                    cam2_vsync,
  input  logic                    cam2_href,
  input  logic [pix_w-1:0]        cam2_data,
  output logic                    frame_start,
  output logic                    pix_valid,
  output logic [pix_w-1:0]        pix_data
);

  // pixel clock side
  logic             wr_en1;
  logic             wr_en2;
  logic [pix_w-1:0] wr_data1;
  logic [pix_w-1:0] wr_data2;
  // system clock side
  logic             rd_en1;
  logic             rd_en2;
  logic             rd_empty1;
  logic             rd_empty2;
  logic [pix_w-1:0] rd_data1;
  logic [pix_w-1:0] rd_data2;

  ////////////////////
  // camera 1 path
  ////////////////////
  cmos_capture u_cap1 (
    .pclk (cam1_pclk), .rst (rst), .vsync (cam1_vsync), .href (cam1_href),
    .data (cam1_data), .wr_en (wr_en1), .wr_data (wr_data1)
  );

  async_fifo u_fifo1 (
    .wr_clk (cam1_pclk), .rd_clk (clk), .rst (rst),
    .wr_en (wr_en1), .rd_en (rd_en1), .wr_data (wr_data1),
    .rd_data (rd_data1), .rd_empty (rd_empty1)
  );

  ////////////////////
  // camera 2 path
  ////////////////////
  cmos_capture u_cap2 (
    .pclk (cam2_pclk), .rst (rst), .vsync (cam2_vsync), .href (cam2_href),
    .data (cam2_data), .wr_en (wr_en2), .wr_data (wr_data2)
  );

  async_fifo u_fifo2 (
    .wr_clk (cam2_pclk), .rd_clk (clk), .rst (rst),
    .wr_en (wr_en2), .rd_en (rd_en2), .wr_data (wr_data2),
    .rd_data (rd_data2), .rd_empty (rd_empty2)
  );

  // side by side merge, frame timing from camera 1
  line_mixer u_mixer (
    .clk (clk), .rst (rst), .frame_vsync (cam1_vsync), .shift_w (shift_w),
    .rd_data1 (rd_data1), .rd_data2 (rd_data2),
    .rd_empty1 (rd_empty1), .rd_empty2 (rd_empty2),
    .rd_en1 (rd_en1), .rd_en2 (rd_en2),
    .frame_start (frame_start), .pix_valid (pix_valid), .pix_data (pix_data)
  );

endmodule

/* line_mixer.sv */
module line_mixer import mix_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    frame_vsync,
  input  logic [shift_w_bits-1:0] shift_w,
  input  logic [pix_w-1:0]        rd_data1,
  input  logic [pix_w-1:0]        rd_data2,
  input  logic                    rd_empty1,
  input  logic                    rd_empty2,
  output logic                    rd_en1,
  output logic                    rd_en2,
  output logic                    frame_start,
  output logic                    pix_valid,
  output logic [pix_w-1:0]        pix_data
);

  logic [2:0]              state;
  logic [cnt_w-1:0]        col;       // position inside current part
  logic [cnt_w-1:0]        line;      // decimated line number
  logic [shift_w_bits-1:0] shift_q;   // held for the whole frame
  logic [cnt_w-1:0]        shift_ext;
  logic                    col_half;  // last word of a half line
  logic                    vs_q0;
  logic                    vs_q1;
  logic                    vs_q2;

  assign shift_ext = cnt_w'(shift_q);
  assign col_half  = (col == cnt_w'(half_w - 1));

  // pop only while the part is active and data sits at the head
  assign rd_en1 = (state == st_left)  & ~rd_empty1;
  assign rd_en2 = (state == st_right) & ~rd_empty2;

  ////////////////////
  // line state machine
  ////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state   <= st_idle;
      col     <= '0;
      line    <= '0;
      shift_q <= '0;
    end else begin
      case (state)
        st_idle: begin
          shift_q <= shift_w;         // sample shift between frames
          col     <= '0;
          line    <= '0;
          if (!rd_empty1) state <= st_left;
        end
        st_left: begin
          if (rd_en1) begin           // stall holds col on empty
            col <= col_half ? '0 : col + 1'b1;
            if (col_half) state <= st_right;
          end
        end
        st_right: begin
          if (rd_en2) begin
            col <= col_half ? '0 : col + 1'b1;
            if (col_half) state <= (shift_q == '0) ? st_end : st_zero;
          end
        end
        st_zero: begin
          col <= col + 1'b1;
          if (col == shift_ext - 1'b1) begin // last pad word
            col   <= '0;
            state <= st_end;
          end
        end
        st_end: begin
          if (line == cnt_w'(half_h - 1)) begin
            line  <= '0;
            state <= st_idle;             // frame done
          end else begin
            line  <= line + 1'b1;
            state <= st_left;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  ////////////////////
  // output register
  ////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) pix_valid <= 1'b0;
    else begin
      case (state)
        st_left:  pix_valid <= rd_en1;
        st_right: pix_valid <= rd_en2 & (col >= shift_ext); // drop first shift words
        st_zero:  pix_valid <= 1'b1;
        default:  pix_valid <= 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      st_left:  pix_data <= rd_data1;
      st_right: pix_data <= rd_data2;
      st_zero:  pix_data <= '0;      // padding
      default:  pix_data <= pix_data;
    endcase
  end

  // camera 1 vsync into clk, rise becomes frame_start
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      vs_q0       <= 1'b0;
      vs_q1       <= 1'b0;
      vs_q2       <= 1'b0;
      frame_start <= 1'b0;
    end else begin
      vs_q0       <= frame_vsync;
      vs_q1       <= vs_q0;
      vs_q2       <= vs_q1;
      frame_start <= vs_q1 & ~vs_q2;  // one clk wide
    end
  end

endmodule

/* async_fifo.sv */
module async_fifo import mix_pkg::*; (
  input  logic             wr_clk,
  input  logic             rd_clk,
  input  logic             rst,
  input  logic             wr_en,
  input  logic             rd_en,
  input  logic [pix_w-1:0] wr_data,
  output logic [pix_w-1:0] rd_data,
  output logic             rd_empty
);

  logic [pix_w-1:0] mem [2**fifo_aw];

  // pointers carry one extra wrap bit
  logic [fifo_aw:0] wr_bin;
  logic [fifo_aw:0] wr_bin_nxt;
  logic [fifo_aw:0] wr_gray;
  logic [fifo_aw:0] rd_bin;
  logic [fifo_aw:0] rd_bin_nxt;
  logic [fifo_aw:0] rd_gray;
  logic [fifo_aw:0] rd_gray_w1;  // read ptr, write domain
  logic [fifo_aw:0] rd_gray_w2;
  logic [fifo_aw:0] wr_gray_r1;  // write ptr, read domain
  logic [fifo_aw:0] wr_gray_r2;
  logic             wr_full;
  logic             wr_ok;
  logic             rd_ok;

  function automatic logic [fifo_aw:0] bin2gray(input logic [fifo_aw:0] b);
    return b ^ (b >> 1);
  endfunction

  ////////////////////
  // write side
  ////////////////////
  // full when gray ptrs differ only in the two top bits
  assign wr_full    = (wr_gray == {~rd_gray_w2[fifo_aw:fifo_aw-1], rd_gray_w2[fifo_aw-2:0]});
  assign wr_ok      = wr_en & ~wr_full;   // writes into a full fifo are lost
  assign wr_bin_nxt = wr_bin + (fifo_aw + 1)'(wr_ok);

  always_ff @(posedge wr_clk or posedge rst) begin
    if (rst) begin
      wr_bin  <= '0;
      wr_gray <= '0;
    end else begin
      wr_bin  <= wr_bin_nxt;
      wr_gray <= bin2gray(wr_bin_nxt);
    end
  end

  always_ff @(posedge wr_clk) begin
    if (wr_ok) mem[wr_bin[fifo_aw-1:0]] <= wr_data;
  end

  // read pointer into write clock
  always_ff @(posedge wr_clk or posedge rst) begin
    if (rst) begin
      rd_gray_w1 <= '0;
      rd_gray_w2 <= '0;
    end else begin
      rd_gray_w1 <= rd_gray;
      rd_gray_w2 <= rd_gray_w1;
    end
  end

  ////////////////////
  // read side
  ////////////////////
  assign rd_empty   = (rd_gray == wr_gray_r2);
  assign rd_ok      = rd_en & ~rd_empty;
  assign rd_bin_nxt = rd_bin + (fifo_aw + 1)'(rd_ok);
  assign rd_data    = mem[rd_bin[fifo_aw-1:0]]; // head word, fall-through

  always_ff @(posedge rd_clk or posedge rst) begin
    if (rst) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else begin
      rd_bin  <= rd_bin_nxt;
      rd_gray <= bin2gray(rd_bin_nxt);
    end
  end

  // write pointer into read clock, 2..4 cycles until visible
  always_ff @(posedge rd_clk or posedge rst) begin
    if (rst) begin
      wr_gray_r1 <= '0;
      wr_gray_r2 <= '0;
    end else begin
      wr_gray_r1 <= wr_gray;
      wr_gray_r2 <= wr_gray_r1;
    end
  end

endmodule

/* cmos_capture.sv */
module cmos_capture import mix_pkg::*; (
  input  logic             pclk,
  input  logic             rst,
  input  logic             vsync,
  input  logic             href,
  input  logic [pix_w-1:0] data,
  output logic             wr_en,
  output logic [pix_w-1:0] wr_data
);

  logic             vs_q0;     // first sync stage
  logic             vs_q1;     // second stage, old value for edge detect
  logic             vs_rise;
  logic             frame_en;  // sticky, set by first vsync
  logic [cnt_w-1:0] col;
  logic [cnt_w-1:0] row;
  logic             col_last;

  ////////////////////
  // vsync edge detect
  ////////////////////
  always_ff @(posedge pclk or posedge rst) begin
    if (rst) begin
      vs_q0 <= 1'b0;
      vs_q1 <= 1'b0;
    end else begin
      vs_q0 <= vsync;
      vs_q1 <= vs_q0;
    end
  end

  assign vs_rise = vs_q0 & ~vs_q1;

  // pixels before the first frame are never stored
  always_ff @(posedge pclk or posedge rst) begin
    if (rst)          frame_en <= 1'b0;
    else if (vs_rise) frame_en <= 1'b1;
  end

  ////////////////////
  // column / row counters
  ////////////////////
  assign col_last = (col == cnt_w'(img_w - 1));

  always_ff @(posedge pclk or posedge rst) begin
    if (rst) begin
      col <= '0;
      row <= '0;
    end else if (vs_rise) begin   // restart at top of frame
      col <= '0;
      row <= '0;
    end else if (href) begin
      col <= col_last ? '0 : col + 1'b1;
      if (col_last)
        row <= (row == cnt_w'(img_h - 1)) ? '0 : row + 1'b1; // next line
    end
  end

  // keep even rows and even columns only
  assign wr_en   = href & frame_en & ~col[0] & ~row[0];
  assign wr_data = data; // word passes straight to the fifo

endmodule

/* mix_pkg.sv */
package mix_pkg;

  ////////////////////
  // pixel and image sizes
  ////////////////////
  localparam int pix_w  = 16;          // one pixel word
  localparam int img_w  = 16;          // source line, pixels
  localparam int img_h  = 8;           // source frame, lines
  localparam int half_w = img_w / 2;   // after 2:1 horizontal decimation
  localparam int half_h = img_h / 2;   // after 2:1 vertical decimation

  // counter widths
  localparam int cnt_w        = 5;     // column / row / line counters
  localparam int shift_w_bits = 3;     // shift_w spans 0 .. half_w-1

  // fifo address bits, 32 words holds a whole decimated frame
  localparam int fifo_aw = 5;

  ////////////////////
  // line mixer state codes
  ////////////////////
  localparam logic [2:0] st_idle  = 3'd0; // wait for camera 1 data
  localparam logic [2:0] st_left  = 3'd1; // half line from fifo 1
  localparam logic [2:0] st_right = 3'd2; // half line from fifo 2
  localparam logic [2:0] st_zero  = 3'd3; // pad with zeros
  localparam logic [2:0] st_end   = 3'd4; // line bookkeeping

endpackage
